// File: rtl/sram_pkg.sv
// shared geometry, address map, AXI response codes and enums for the scratchpad; import with ::*
package sram_pkg;

    // memory geometry
    localparam int mem_words       = 1024;
    localparam int data_width      = 32;
    localparam int strb_width      = data_width / 8;  // one strobe per byte lane
    localparam int word_addr_width = $clog2(mem_words);
    localparam int axil_addr_width = 13;              // covers memory plus register window

    // address map, byte addresses
    localparam logic [axil_addr_width-1:0] reg_base         = 13'h1000;
    localparam logic [axil_addr_width-1:0] reg_pattern_addr = 13'h1000;
    localparam logic [axil_addr_width-1:0] reg_base_addr    = 13'h1004;
    localparam logic [axil_addr_width-1:0] reg_len_addr     = 13'h1008;
    localparam logic [axil_addr_width-1:0] reg_ctrl_addr    = 13'h100C;  // bit 0 go / busy

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        st_idle,
        st_write_mem,     // memory or register write happens here
        st_write_resp,
        st_read_issue,    // address presented to the SRAM
        st_read_capture,  // SRAM data valid, latched into rdata
        st_read_resp
    } axil_state_e;

    typedef enum logic [2:0] {
        sel_pattern,
        sel_base,
        sel_length,
        sel_control,
        sel_none          // unmapped, answers SLVERR
    } reg_sel_e;

endpackage

// File: rtl/dual_port_sram.sv
// inferred dual-port SRAM with byte write masks and a registered read on each port, one clock
`timescale 1ns/1ps

module dual_port_sram
    import sram_pkg::*;
(
    input  logic                       clk,
    // port a
    input  logic [word_addr_width-1:0] addr_a,
    input  logic [data_width-1:0]      wdata_a,
    input  logic [strb_width-1:0]      wmask_a,
    input  logic                       we_a,
    output logic [data_width-1:0]      rdata_a,
    // port b
    input  logic [word_addr_width-1:0] addr_b,
    input  logic [data_width-1:0]      wdata_b,
    input  logic [strb_width-1:0]      wmask_b,
    input  logic                       we_b,
    output logic [data_width-1:0]      rdata_b
);

    logic [strb_width-1:0][7:0] mem [mem_words];  // no init, contents undefined until written

    // both ports gathered so one process handles them alike
    logic [word_addr_width-1:0] addr [2];
    logic [data_width-1:0]      wdata [2];
    logic [strb_width-1:0]      wmask [2];
    logic [1:0]                 we;
    logic [data_width-1:0]      rdata_q [2];

    assign addr  = '{addr_a, addr_b};
    assign wdata = '{wdata_a, wdata_b};
    assign wmask = '{wmask_a, wmask_b};
    assign we    = {we_b, we_a};

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (we[p]) begin
                for (int j = 0; j < strb_width; j++) begin
                    if (wmask[p][j]) begin
                        mem[addr[p]][j] <= wdata[p][j*8 +: 8];  // masked byte lane
                    end
                end
            end
            rdata_q[p] <= mem[addr[p]];  // read-during-write gives old data
        end
    end

    assign rdata_a = rdata_q[0];
    assign rdata_b = rdata_q[1];

endmodule

// File: rtl/fill_counter.sv
// fill engine writing one pattern word per cycle over a wrapping word range via SRAM port 1
`timescale 1ns/1ps

module fill_counter
    import sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       go,          // one-cycle start pulse
    input  logic [data_width-1:0]      pattern,
    input  logic [word_addr_width-1:0] base,
    input  logic [word_addr_width:0]   len,         // words to write, 0 does nothing
    output logic                       busy,
    output logic [word_addr_width-1:0] fill_addr,
    output logic [data_width-1:0]      fill_wdata,
    output logic                       fill_we
);

    logic [word_addr_width-1:0] addr_q;       // next word to write
    logic [word_addr_width:0]   remaining_q;  // words still to go
    logic [data_width-1:0]      pattern_q;
    logic                       active;

    assign active = (remaining_q != '0);

    // address and length counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q      <= '0;
            remaining_q <= '0;
        end else if (go) begin
            addr_q      <= base;
            remaining_q <= len;
        end else if (active) begin
            addr_q      <= addr_q + 1'b1;  // wraps at mem_words by width
            remaining_q <= remaining_q - 1'b1;
        end
    end

    // pattern held for the whole run
    always_ff @(posedge clk) begin
        if (go) begin
            pattern_q <= pattern;
        end
    end

    assign busy       = active;
    assign fill_we    = active;     // one word per cycle
    assign fill_addr  = addr_q;
    assign fill_wdata = pattern_q;

    // the FSM gates go on busy, a restart mid-run would corrupt the range
    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
        go |-> !busy);

endmodule

// File: rtl/axil_access_fsm.sv
// AXI4-Lite slave FSM driving SRAM port 0 and holding the fill registers; used by axil_sram_top
`timescale 1ns/1ps

module axil_access_fsm
    import sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // aw channel
    input  logic [axil_addr_width-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    // w channel
    input  logic [data_width-1:0]      wdata,
    input  logic [strb_width-1:0]      wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    // b channel
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // ar channel
    input  logic [axil_addr_width-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    // r channel
    output logic [data_width-1:0]      rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    // SRAM port 0
    output logic [word_addr_width-1:0] mem_addr,
    output logic [data_width-1:0]      mem_wdata,
    output logic [strb_width-1:0]      mem_wmask,
    output logic                       mem_we,
    input  logic [data_width-1:0]      mem_rdata,
    // fill engine control
    output logic                       fill_go,
    output logic [data_width-1:0]      fill_pattern,
    output logic [word_addr_width-1:0] fill_base,
    output logic [word_addr_width:0]   fill_len,   // one extra bit so a full 1024 fits
    input  logic                       fill_busy
);

    axil_state_e                state_q;
    logic [axil_addr_width-1:0] addr_q;    // latched byte address of the current access
    logic [data_width-1:0]      wdata_q;
    logic [strb_width-1:0]      wstrb_q;
    logic [data_width-1:0]      rdata_q;
    logic [1:0]                 resp_q;
    logic                       mem_hit;
    reg_sel_e                   reg_sel;
    logic [data_width-1:0]      reg_rdata;
    logic                       ar_fire;
    logic                       reg_wr;

    // byte-lane merge used for register writes
    function automatic logic [data_width-1:0] merge_bytes(
        input logic [data_width-1:0] old_val,
        input logic [data_width-1:0] new_val,
        input logic [strb_width-1:0] strb
    );
        logic [data_width-1:0] res;
        res = old_val;
        for (int j = 0; j < strb_width; j++) begin
            if (strb[j]) begin
                res[j*8 +: 8] = new_val[j*8 +: 8];
            end
        end
        return res;
    endfunction

    // decode of the latched address
    assign mem_hit = (addr_q < reg_base);  // 0x0000..0x0FFF

    always_comb begin
        case ({addr_q[axil_addr_width-1:2], 2'b00})  // byte offset ignored
            reg_pattern_addr: reg_sel = sel_pattern;
            reg_base_addr:    reg_sel = sel_base;
            reg_len_addr:     reg_sel = sel_length;
            reg_ctrl_addr:    reg_sel = sel_control;
            default:          reg_sel = sel_none;
        endcase
    end

    // write wins over a read arriving in the same cycle
    assign awready = (state_q == st_idle) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state_q == st_idle) && !awvalid && !wvalid;
    assign ar_fire = arready && arvalid;

    // SRAM port 0 always addressed from the latched access
    assign mem_addr  = addr_q[word_addr_width+1:2];
    assign mem_wdata = wdata_q;
    assign mem_wmask = wstrb_q;
    assign mem_we    = (state_q == st_write_mem) && mem_hit;

    assign reg_wr  = (state_q == st_write_mem) && !fill_busy;  // frozen while a fill runs
    assign fill_go = reg_wr && (reg_sel == sel_control) && wstrb_q[0] && wdata_q[0];

    // register read mux
    always_comb begin
        case (reg_sel)
            sel_pattern: reg_rdata = fill_pattern;
            sel_base:    reg_rdata = data_width'(fill_base);
            sel_length:  reg_rdata = data_width'(fill_len);
            sel_control: reg_rdata = {{(data_width-1){1'b0}}, fill_busy};
            default:     reg_rdata = '0;  // unmapped reads return zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (awready) begin
                        state_q <= st_write_mem;
                    end else if (ar_fire) begin
                        state_q <= st_read_issue;
                    end
                end
                st_write_mem:    state_q <= st_write_resp;
                st_write_resp:   if (bready) state_q <= st_idle;  // stall until accepted
                st_read_issue:   state_q <= st_read_capture;
                st_read_capture: state_q <= st_read_resp;
                st_read_resp:    if (rready) state_q <= st_idle;
                default:         state_q <= st_idle;
            endcase
        end
    end

    // access payload latched on each transfer
    always_ff @(posedge clk) begin
        if (awready) begin
            addr_q  <= awaddr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (ar_fire) begin
            addr_q <= araddr;
        end
        if (state_q == st_write_mem || state_q == st_read_capture) begin
            resp_q <= (mem_hit || reg_sel != sel_none) ? resp_okay : resp_slverr;
        end
        if (state_q == st_read_capture) begin
            rdata_q <= mem_hit ? mem_rdata : reg_rdata;  // SRAM data valid this cycle
        end
    end

    // fill registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_pattern <= '0;
            fill_base    <= '0;
            fill_len     <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                sel_pattern: fill_pattern <= merge_bytes(fill_pattern, wdata_q, wstrb_q);
                sel_base: begin
                    fill_base <= word_addr_width'(
                        merge_bytes(data_width'(fill_base), wdata_q, wstrb_q));
                end
                sel_length: begin
                    fill_len <= (word_addr_width+1)'(
                        merge_bytes(data_width'(fill_len), wdata_q, wstrb_q));
                end
                default: ;  // go is a pulse and stores nothing
            endcase
        end
    end

    assign bvalid = (state_q == st_write_resp);
    assign bresp  = resp_q;
    assign rvalid = (state_q == st_read_resp);
    assign rdata  = rdata_q;
    assign rresp  = resp_q;

    // responses hold until taken
    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: rtl/axil_sram_top.sv
// top level of the AXI4-Lite scratchpad, joins the slave FSM, the fill engine and the SRAM
`timescale 1ns/1ps

module axil_sram_top
    import sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // aw channel
    input  logic [axil_addr_width-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    // w channel
    input  logic [data_width-1:0]      wdata,
    input  logic [strb_width-1:0]      wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    // b channel
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // ar channel
    input  logic [axil_addr_width-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    // r channel
    output logic [data_width-1:0]      rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    // SRAM port 0, AXI side
    logic [word_addr_width-1:0] mem_addr;
    logic [data_width-1:0]      mem_wdata;
    logic [strb_width-1:0]      mem_wmask;
    logic                       mem_we;
    logic [data_width-1:0]      mem_rdata;

    // fill control and SRAM port 1
    logic                       fill_go;
    logic [data_width-1:0]      fill_pattern;
    logic [word_addr_width-1:0] fill_base;
    logic [word_addr_width:0]   fill_len;
    logic                       fill_busy;
    logic [word_addr_width-1:0] fill_addr;
    logic [data_width-1:0]      fill_wdata;
    logic                       fill_we;
    logic [strb_width-1:0]      fill_mask;

    assign fill_mask = '1;  // fill always writes whole words

    axil_access_fsm axil_access_fsm_inst (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .mem_addr, .mem_wdata, .mem_wmask, .mem_we, .mem_rdata,
        .fill_go, .fill_pattern, .fill_base, .fill_len, .fill_busy
    );

    fill_counter fill_counter_inst (
        .clk, .rst_n,
        .go         (fill_go),
        .pattern    (fill_pattern),
        .base       (fill_base),
        .len        (fill_len),
        .busy       (fill_busy),
        .fill_addr, .fill_wdata, .fill_we
    );

    dual_port_sram dual_port_sram_inst (
        .clk,
        .addr_a  (mem_addr),
        .wdata_a (mem_wdata),
        .wmask_a (mem_wmask),
        .we_a    (mem_we),
        .rdata_a (mem_rdata),
        .addr_b  (fill_addr),
        .wdata_b (fill_wdata),
        .wmask_b (fill_mask),
        .we_b    (fill_we),
        .rdata_b ()             // fill engine never reads
    );

endmodule

// File: tb/axil_sram_tb.sv
// testbench for axil_sram_top that drives AXI4-Lite traffic and checks it against a reference model
`timescale 1ns/1ps

module axil_sram_tb
    import sram_pkg::*;
();

    localparam int wait_limit = 64;   // cycles allowed per handshake
    localparam int poll_limit = 500;  // status reads allowed per fill

    logic                       clk, rst_n;
    logic [axil_addr_width-1:0] awaddr, araddr;
    logic [data_width-1:0]      wdata, rdata;
    logic [strb_width-1:0]      wstrb;
    logic                       awvalid, awready, wvalid, wready, bvalid, bready;
    logic                       arvalid, arready, rvalid, rready;
    logic [1:0]                 bresp, rresp;

    // reference model
    logic [data_width-1:0] ref_mem [mem_words];
    logic [data_width-1:0] ref_pattern, ref_base, ref_len;
    logic                  ref_busy;

    // expected write responses
    logic [1:0]            exp_b_q[$];
    logic [1:0]            b_entry;
    // expected reads as {check enable, resp, data}
    logic [data_width+2:0] exp_r_q[$];
    logic [data_width+2:0] r_entry;

    integer seed;
    int     max_delay;  // upper bound of ready back-pressure

    axil_sram_top axil_sram_top_inst (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_value(input logic [data_width-1:0] actual,
                                 input logic [data_width-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        abort_run();
    endtask

    function automatic logic [data_width-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_delay();
        if (max_delay == 0) return 0;
        return $unsigned($random(seed)) % (max_delay + 1);
    endfunction

    // byte address of a word index wrapped modulo mem_words
    function automatic logic [axil_addr_width-1:0] word_addr(input int i);
        logic [word_addr_width-1:0] w;
        w = word_addr_width'(i);
        return axil_addr_width'({w, 2'b00});
    endfunction

    function automatic logic [data_width-1:0] byte_merge(input logic [data_width-1:0] old_val,
            input logic [data_width-1:0] new_val, input logic [strb_width-1:0] strb);
        logic [data_width-1:0] mask;
        for (int j = 0; j < strb_width; j++) begin
            mask[j*8 +: 8] = {8{strb[j]}};  // strobe widened to its byte
        end
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    // {resp, data} that a read of addr must return
    function automatic logic [data_width+1:0] expected_read(input logic [axil_addr_width-1:0] addr);
        logic [axil_addr_width-1:0] word;
        word = {addr[axil_addr_width-1:2], 2'b00};
        if (addr < reg_base) return {resp_okay, ref_mem[addr[word_addr_width+1:2]]};
        case (word)
            reg_pattern_addr: return {resp_okay, ref_pattern};
            reg_base_addr:    return {resp_okay, ref_base};
            reg_len_addr:     return {resp_okay, ref_len};
            reg_ctrl_addr:    return {resp_okay, {(data_width-1){1'b0}}, ref_busy};
            default:          return {resp_slverr, {data_width{1'b0}}};
        endcase
    endfunction

    // updates the model for one write and gives the expected bresp
    function automatic logic [1:0] apply_write(input logic [axil_addr_width-1:0] addr,
            input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
        logic [axil_addr_width-1:0] word;
        word = {addr[axil_addr_width-1:2], 2'b00};
        if (addr < reg_base) begin
            ref_mem[addr[word_addr_width+1:2]] = byte_merge(ref_mem[addr[word_addr_width+1:2]],
                                                            data, strb);
            return resp_okay;
        end
        case (word)
            reg_pattern_addr: if (!ref_busy) ref_pattern = byte_merge(ref_pattern, data, strb);
            reg_base_addr: begin
                if (!ref_busy) ref_base = byte_merge(ref_base, data, strb) & (mem_words - 1);
            end
            reg_len_addr: begin
                if (!ref_busy) ref_len = byte_merge(ref_len, data, strb) & (2 * mem_words - 1);
            end
            reg_ctrl_addr: begin
                if (!ref_busy && strb[0] && data[0] && ref_len != 0) ref_busy = 1'b1;
            end
            default: return resp_slverr;  // unmapped so nothing changes
        endcase
        return resp_okay;
    endfunction

    task automatic axil_write(input logic [axil_addr_width-1:0] addr,
                              input logic [data_width-1:0] data, input logic [strb_width-1:0] strb);
        int n;
        logic [1:0] first_resp;
        exp_b_q.push_back(apply_write(addr, data, strb));
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            if (n == wait_limit) report_timeout("awready and wready");
            n++;
            @(negedge clk);
        end
        @(posedge clk);  // aw and w transfer on this edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            if (n == wait_limit) report_timeout("bvalid");
            n++;
            @(negedge clk);
        end
        first_resp = bresp;
        repeat (rand_delay()) begin  // response must hold under back-pressure
            @(negedge clk);
            compare_value(data_width'(bvalid), 1, "bvalid held under back-pressure");
            compare_value(data_width'(bresp), data_width'(first_resp), "bresp held");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [axil_addr_width-1:0] addr, input logic chk,
                             output logic [data_width-1:0] data);
        int n;
        logic [data_width-1:0] first_data;
        logic [1:0] first_resp;
        exp_r_q.push_back({chk, expected_read(addr)});
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            if (n == wait_limit) report_timeout("arready");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            if (n == wait_limit) report_timeout("rvalid");
            n++;
            @(negedge clk);
        end
        first_data = rdata;
        first_resp = rresp;
        repeat (rand_delay()) begin
            @(negedge clk);
            compare_value(data_width'(rvalid), 1, "rvalid held under back-pressure");
            compare_value(rdata, first_data, "rdata held");
            compare_value(data_width'(rresp), data_width'(first_resp), "rresp held");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        data = first_data;
    endtask

    // polls status until the fill is over and then applies it to the model
    task automatic wait_fill_done();
        int n;
        logic [data_width-1:0] st;
        n = 0;
        axil_read(reg_ctrl_addr, 1'b0, st);
        while (st[0]) begin
            if (n == poll_limit) report_timeout("fill busy to clear");
            n++;
            axil_read(reg_ctrl_addr, 1'b0, st);
        end
        for (int i = 0; i < int'(ref_len); i++) begin
            ref_mem[word_addr_width'(int'(ref_base) + i)] = ref_pattern;  // wraps like the engine
        end
        ref_busy = 1'b0;
    endtask

    // compares every b and r transfer with the queued expectation
    always @(negedge clk) begin
        if (rst_n && bvalid && bready) begin
            if (exp_b_q.size() == 0) begin
                $display("write response arrived with no write outstanding");
                abort_run();
            end
            b_entry = exp_b_q.pop_front();
            compare_value(data_width'(bresp), data_width'(b_entry), "bresp");
        end
        if (rst_n && rvalid && rready) begin
            if (exp_r_q.size() == 0) begin
                $display("read response arrived with no read outstanding");
                abort_run();
            end
            r_entry = exp_r_q.pop_front();
            if (r_entry[data_width+2]) begin  // poll reads are not checked here
                compare_value(data_width'(rresp), data_width'(r_entry[data_width+1:data_width]),
                              $sformatf("rresp at %h", araddr));
                compare_value(rdata, r_entry[data_width-1:0], $sformatf("rdata at %h", araddr));
            end
        end
    end

    initial begin
        logic [data_width-1:0] rd;
        logic [15:0] iv;
        logic [axil_addr_width-1:0] addr_q[$];
        int idx;
        seed = 32'h6dc1;
        max_delay = 0;
        ref_busy = 1'b0;
        ref_pattern = '0;
        ref_base = '0;
        ref_len = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // fill registers come out of reset as 0
        for (int r = 0; r < 4; r++) axil_read(reg_base + axil_addr_width'(4 * r), 1'b1, rd);

        // preload every word with a value unique to its index
        for (int i = 0; i < mem_words; i++) begin
            iv = 16'(i);
            axil_write(word_addr(i), {~iv, iv}, 4'hf);
        end

        // full-word writes followed by reads
        repeat (24) begin
            addr_q.push_back(word_addr($unsigned($random(seed)) % mem_words));
            axil_write(addr_q[$], rand_word(), 4'hf);
        end
        while (addr_q.size() != 0) axil_read(addr_q.pop_front(), 1'b1, rd);

        // partial strobes merge bytes
        repeat (24) begin
            idx = $unsigned($random(seed)) % mem_words;
            axil_write(word_addr(idx), rand_word(), strb_width'($random(seed)));
            axil_read(word_addr(idx), 1'b1, rd);
        end

        // fill that wraps past word 1023
        axil_write(reg_pattern_addr, rand_word(), 4'hf);
        axil_write(reg_base_addr, 32'd1000, 4'hf);
        axil_write(reg_len_addr, 32'd40, 4'hf);
        axil_write(reg_ctrl_addr, 32'd1, 4'hf);
        axil_read(reg_ctrl_addr, 1'b1, rd);  // busy right after the write response
        wait_fill_done();
        for (int i = -2; i < 42; i++) axil_read(word_addr(1000 + i), 1'b1, rd);

        // register readback
        axil_write(reg_pattern_addr, rand_word(), 4'hf);
        axil_write(reg_base_addr, rand_word(), 4'hf);
        axil_write(reg_len_addr, rand_word(), 4'hf);
        for (int r = 0; r < 3; r++) axil_read(reg_base + axil_addr_width'(4 * r), 1'b1, rd);

        // register writes during a long fill are dropped
        axil_write(reg_len_addr, 32'd600, 4'hf);
        axil_write(reg_ctrl_addr, 32'd1, 4'hf);
        axil_read(reg_ctrl_addr, 1'b1, rd);
        axil_write(reg_pattern_addr, rand_word(), 4'hf);
        axil_write(reg_base_addr, rand_word(), 4'hf);
        axil_write(reg_len_addr, rand_word(), 4'hf);
        axil_write(reg_ctrl_addr, 32'd1, 4'hf);
        for (int r = 0; r < 4; r++) axil_read(reg_base + axil_addr_width'(4 * r), 1'b1, rd);
        wait_fill_done();

        // zero length never sets busy
        axil_write(reg_len_addr, 32'd0, 4'hf);
        axil_write(reg_ctrl_addr, 32'd1, 4'hf);
        axil_read(reg_ctrl_addr, 1'b1, rd);

        // unmapped window answers SLVERR
        axil_read(13'h1010, 1'b1, rd);
        axil_read(13'h1ffc, 1'b1, rd);
        axil_write(13'h1010, rand_word(), 4'hf);
        axil_write(13'h1800, rand_word(), 4'hf);
        axil_write(13'h1ffc, rand_word(), 4'hf);
        for (int r = 0; r < 4; r++) axil_read(reg_base + axil_addr_width'(4 * r), 1'b1, rd);

        // random back-pressure on bready and rready
        max_delay = 6;
        repeat (40) begin
            idx = $unsigned($random(seed)) % mem_words;
            if ($random(seed) & 1) begin
                axil_write(word_addr(idx), rand_word(), strb_width'($random(seed)));
            end else begin
                axil_read(word_addr(idx), 1'b1, rd);
            end
        end
        for (int i = 0; i < mem_words; i++) axil_read(word_addr(i), 1'b1, rd);  // full sweep

        if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
            $display("responses missing, %0d writes and %0d reads never completed",
                     exp_b_q.size(), exp_r_q.size());
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: axil_sram.f
rtl/sram_pkg.sv
rtl/dual_port_sram.sv
rtl/fill_counter.sv
rtl/axil_access_fsm.sv
rtl/axil_sram_top.sv
tb/axil_sram_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the scratchpad testbench with Verilator and runs it, exit status is the result

cd "$(dirname "$0")" || exit 1

# compile rtl and testbench into one binary, assertions enabled
verilator --binary --timing --assert \
    --top-module axil_sram_tb \
    -f axil_sram.f \
    -o axil_sram_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

# run, a failing check ends in a nonzero status
./obj_dir/axil_sram_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit "$status"
